/* source/mem_pkg.sv */
package mem_pkg;

    // data and instruction words
    typedef logic [31:0] word_t;        // one 32-bit word, little endian

    // single byte, one bank entry
    typedef logic [7:0] byte_t;         // width of one bank

    // wishbone byte select
    typedef logic [3:0] sel_t;          // bit k -> byte a+k of the access

    // bank index
    typedef logic [1:0] lane_t;         // address mod 4

    // default byte address width
    localparam int DEFAULT_ADDR_W = 16; // 64 KiB, 16 KiB per bank

    // data front fsm
    typedef enum logic {
        FRONT_IDLE = 1'b0,              // waiting for cyc and stb
        FRONT_ACK  = 1'b1               // ack cycle of the accepted request
    } front_state_t;

    // the four banks are interleaved by address bits [1:0]
    // byte at address a lives in bank a[1:0], row a[ADDR_W-1:2]
    // a word at a covers banks a, a+1, a+2, a+3 (mod 4)
    // rows step by one when the lane index crosses bank 3
    // address arithmetic wraps at the memory size



endpackage

/* source/wb_data_front.sv */
`timescale 1ns/1ps

module wb_data_front #(
    parameter int ADDR_W = mem_pkg::DEFAULT_ADDR_W  // byte address width
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                wb_cyc_i,       // bus cycle active
    input  logic                wb_stb_i,       // strobe, request valid
    input  logic                wb_we_i,        // 1 = write
    input  mem_pkg::sel_t       wb_sel_i,       // byte selects relative to adr
    input  logic [ADDR_W-1:0]   wb_adr_i,       // byte address, any alignment
    input  mem_pkg::word_t      wb_dat_i,       // write data
    output logic                wb_ack_o,       // one cycle per request
    output logic                req_valid_o,    // accept strobe toward steering
    output logic                req_we_o,
    output mem_pkg::sel_t       req_sel_o,
    output logic [ADDR_W-1:0]   req_addr_o,
    output mem_pkg::word_t      req_data_o,
    output mem_pkg::lane_t      rd_lane_o       // low addr bits of last access
);

    mem_pkg::front_state_t state_q;             // current fsm state
    mem_pkg::front_state_t state_d;             // next state
    mem_pkg::lane_t        rd_lane_q;           // lane of the accepted read

    // a request is taken only while idle, so ack is never high on accept
    assign req_valid_o = (state_q == mem_pkg::FRONT_IDLE) && wb_cyc_i && wb_stb_i;

    // request fields pass through in the accept cycle only
    assign req_we_o   = req_valid_o & wb_we_i;
    assign req_sel_o  = req_valid_o ? wb_sel_i : '0;
    assign req_addr_o = req_valid_o ? wb_adr_i : '0;
    assign req_data_o = req_valid_o ? wb_dat_i : '0;

    always_comb begin
        state_d = state_q;                      // hold by default
        case (state_q)
            mem_pkg::FRONT_IDLE: begin
                if (req_valid_o) begin
                    state_d = mem_pkg::FRONT_ACK;   // banks act at this edge
                end
            end
            mem_pkg::FRONT_ACK: begin
                state_d = mem_pkg::FRONT_IDLE;      // master sees ack, then moves on
            end
            default: state_d = mem_pkg::FRONT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= mem_pkg::FRONT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // lane follows the bank capture edge
    always_ff @(posedge clk) begin
        if (req_valid_o) begin
            rd_lane_q <= wb_adr_i[1:0];         // rotation amount for read data
        end
    end

    assign wb_ack_o  = (state_q == mem_pkg::FRONT_ACK);   // registered ack
    assign rd_lane_o = rd_lane_q;

    // ack pulses are always separated by an idle cycle
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o);

    // a write with no selected byte would ack without touching memory
    a_wr_sel_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        (req_valid_o && wb_we_i) |-> (wb_sel_i != '0));

endmodule

/* source/lane_steer.sv */
`timescale 1ns/1ps

module lane_steer #(
    parameter int ADDR_W = mem_pkg::DEFAULT_ADDR_W  // byte address width
) (
    input  logic                        req_valid_i,    // accepted data request
    input  logic                        req_we_i,       // write request
    input  mem_pkg::sel_t               req_sel_i,      // selects in lane order
    input  logic [ADDR_W-1:0]           req_addr_i,     // data byte address
    input  mem_pkg::word_t              req_data_i,     // write word in lane order
    input  logic [ADDR_W-1:0]           fetch_addr_i,   // fetch byte address
    output logic [3:0][ADDR_W-3:0]      d_row_o,        // data row per bank
    output logic [3:0][ADDR_W-3:0]      f_row_o,        // fetch row per bank
    output logic [3:0]                  d_we_o,         // per bank write enable
    output mem_pkg::byte_t [3:0]        d_wbyte_o,      // per bank write byte
    output logic                        d_re_o          // data read enable
);

    mem_pkg::lane_t [3:0]       d_lane;     // lane that lands in bank b, data side
    mem_pkg::lane_t [3:0]       f_lane;     // same for fetch
    logic [3:0][ADDR_W-1:0]     d_baddr;    // full byte address per bank, data
    logic [3:0][ADDR_W-1:0]     f_baddr;    // full byte address per bank, fetch

    // bank b holds lane (b - a) mod 4 of the word at a
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            d_lane[b] = mem_pkg::lane_t'(b - req_addr_i[1:0]);
            f_lane[b] = mem_pkg::lane_t'(b - fetch_addr_i[1:0]);

            // a + k, wraps at the top of memory
            d_baddr[b] = req_addr_i + {{(ADDR_W-2){1'b0}}, d_lane[b]};
            f_baddr[b] = fetch_addr_i + {{(ADDR_W-2){1'b0}}, f_lane[b]};

            d_row_o[b] = d_baddr[b][ADDR_W-1:2];   // drop bank bits
            f_row_o[b] = f_baddr[b][ADDR_W-1:2];

            // select bit and data byte follow the lane
            d_we_o[b]    = req_valid_i & req_we_i & req_sel_i[d_lane[b]];
            d_wbyte_o[b] = req_data_i[8*d_lane[b] +: 8];
        end
    end

    // reads fetch all four banks, sel only masks writes
    assign d_re_o = req_valid_i & ~req_we_i;

endmodule

/* source/byte_bank_ram.sv */
`timescale 1ns/1ps

module byte_bank_ram #(
    parameter int ADDR_W = mem_pkg::DEFAULT_ADDR_W  // byte address width
) (
    input  logic                        clk,
    input  logic [3:0][ADDR_W-3:0]      d_row_i,    // data row per bank
    input  logic [3:0]                  d_we_i,     // per bank write enable
    input  mem_pkg::byte_t [3:0]        d_wbyte_i,  // per bank write byte
    input  logic                        d_re_i,     // data read enable
    input  logic [3:0][ADDR_W-3:0]      f_row_i,    // fetch row per bank
    output mem_pkg::byte_t [3:0]        d_rbyte_o,  // registered data bytes
    output mem_pkg::byte_t [3:0]        f_rbyte_o   // registered fetch bytes
);

    localparam int DEPTH = 2 ** (ADDR_W - 2);       // rows per bank

    for (genvar b = 0; b < 4; b++) begin : g_bank

        mem_pkg::byte_t bank_mem [DEPTH];           // one byte lane of memory
        mem_pkg::byte_t d_rbyte_q;                  // data port output register
        mem_pkg::byte_t f_rbyte_q;                  // fetch port output register

        // data port, write or read, never both in one request
        always_ff @(posedge clk) begin
            if (d_we_i[b]) begin
                bank_mem[d_row_i[b]] <= d_wbyte_i[b];
            end
            if (d_re_i) begin
                d_rbyte_q <= bank_mem[d_row_i[b]];  // held until next read
            end
        end

        // fetch port reads every cycle
        // nonblocking read sees the byte before a same-edge write
        always_ff @(posedge clk) begin
            f_rbyte_q <= bank_mem[f_row_i[b]];
        end

        assign d_rbyte_o[b] = d_rbyte_q;
        assign f_rbyte_o[b] = f_rbyte_q;

    end

    // each write belongs to one accepted request, and the front
    // spends the following cycle in ack, so no bank access follows
    a_we_one_request: assert property (@(posedge clk)
        (|d_we_i) |=> (!(|d_we_i) && !d_re_i));

endmodule

/* source/read_realign.sv */
`timescale 1ns/1ps

module read_realign #(
    parameter int ADDR_W = mem_pkg::DEFAULT_ADDR_W  // byte address width
) (
    input  logic                    clk,
    input  mem_pkg::byte_t [3:0]    d_rbyte_i,      // data bytes in bank order
    input  mem_pkg::byte_t [3:0]    f_rbyte_i,      // fetch bytes in bank order
    input  mem_pkg::lane_t          rd_lane_i,      // low bits of the read address
    input  logic [ADDR_W-1:0]       fetch_addr_i,   // current fetch address
    output mem_pkg::word_t          wb_dat_o,       // read word in lane order
    output mem_pkg::word_t          fetch_word_o    // fetched word in lane order
);

    mem_pkg::lane_t f_lane_q;   // fetch low bits, aligned with bank registers

    // fetch bytes are one cycle behind the address
    always_ff @(posedge clk) begin
        f_lane_q <= fetch_addr_i[1:0];
    end

    // lane k comes from bank (a + k) mod 4
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            wb_dat_o[8*k +: 8]     = d_rbyte_i[mem_pkg::lane_t'(rd_lane_i + k)];
            fetch_word_o[8*k +: 8] = f_rbyte_i[mem_pkg::lane_t'(f_lane_q + k)];
        end
    end

    // lane 0 is byte a, lane 3 is byte a+3, little endian
    // rd_lane_i is only refreshed by accepted requests, so it stays
    // in step with d_rbyte_i through the ack cycle














endmodule

/* source/unified_mem_top.sv */
`timescale 1ns/1ps

module unified_mem_top #(
    parameter int ADDR_W = mem_pkg::DEFAULT_ADDR_W  // byte address width, 3 or more
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [ADDR_W-1:0]   fetch_addr_i,   // instruction byte address
    output mem_pkg::word_t      fetch_word_o,   // word one cycle later
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  mem_pkg::sel_t       wb_sel_i,
    input  logic [ADDR_W-1:0]   wb_adr_i,
    input  mem_pkg::word_t      wb_dat_i,
    output mem_pkg::word_t      wb_dat_o,       // valid during ack
    output logic                wb_ack_o
);

    logic                       req_valid;      // front to steering
    logic                       req_we;
    mem_pkg::sel_t              req_sel;
    logic [ADDR_W-1:0]          req_addr;
    mem_pkg::word_t             req_data;
    mem_pkg::lane_t             rd_lane_q;      // front to realign

    logic [3:0][ADDR_W-3:0]     d_row;          // steering to banks
    logic [3:0][ADDR_W-3:0]     f_row;
    logic [3:0]                 d_we;
    mem_pkg::byte_t [3:0]       d_wbyte;
    logic                       d_re;

    mem_pkg::byte_t [3:0]       d_rbyte;        // banks to realign
    mem_pkg::byte_t [3:0]       f_rbyte;

    wb_data_front #(.ADDR_W(ADDR_W)) i_wb_data_front (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_sel_i    (wb_sel_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_o    (wb_ack_o),
        .req_valid_o (req_valid),
        .req_we_o    (req_we),
        .req_sel_o   (req_sel),
        .req_addr_o  (req_addr),
        .req_data_o  (req_data),
        .rd_lane_o   (rd_lane_q)
    );

    lane_steer #(.ADDR_W(ADDR_W)) i_lane_steer (
        .req_valid_i  (req_valid),
        .req_we_i     (req_we),
        .req_sel_i    (req_sel),
        .req_addr_i   (req_addr),
        .req_data_i   (req_data),
        .fetch_addr_i (fetch_addr_i),
        .d_row_o      (d_row),
        .f_row_o      (f_row),
        .d_we_o       (d_we),
        .d_wbyte_o    (d_wbyte),
        .d_re_o       (d_re)
    );

    byte_bank_ram #(.ADDR_W(ADDR_W)) i_byte_bank_ram (
        .clk       (clk),
        .d_row_i   (d_row),
        .d_we_i    (d_we),
        .d_wbyte_i (d_wbyte),
        .d_re_i    (d_re),
        .f_row_i   (f_row),
        .d_rbyte_o (d_rbyte),
        .f_rbyte_o (f_rbyte)
    );

    read_realign #(.ADDR_W(ADDR_W)) i_read_realign (
        .clk          (clk),
        .d_rbyte_i    (d_rbyte),
        .f_rbyte_i    (f_rbyte),
        .rd_lane_i    (rd_lane_q),
        .fetch_addr_i (fetch_addr_i),
        .wb_dat_o     (wb_dat_o),
        .fetch_word_o (fetch_word_o)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real HALF_PERIOD = 5.0    // 10 ns period
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;                   // known level before the first edge
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

endmodule

/* dv/tb_unified_mem.sv */
`timescale 1ns/1ps

module tb_unified_mem;

    localparam int ADDR_W  = mem_pkg::DEFAULT_ADDR_W;  // 64 KiB under test
    localparam int RST_CYC = 10;                        // reset length in cycles

    logic                clk;
    logic                rst_n;
    logic [ADDR_W-1:0]   fetch_addr;
    mem_pkg::word_t      fetch_word;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    mem_pkg::sel_t       wb_sel;
    logic [ADDR_W-1:0]   wb_adr;
    mem_pkg::word_t      wb_dat_w;                      // master to slave
    mem_pkg::word_t      wb_dat_r;                      // slave to master
    logic                wb_ack;

    logic [7:0]          vec_op    [$];                 // W, R or F
    logic [ADDR_W-1:0]   vec_addr  [$];
    mem_pkg::sel_t       vec_sel   [$];
    mem_pkg::word_t      vec_wdata [$];
    mem_pkg::word_t      vec_exp   [$];

    int unsigned         errors      = 0;
    int unsigned         tests       = 0;
    int unsigned         cycles      = 0;
    int unsigned         cycle_limit = 0;
    logic                limit_set   = 1'b0;            // timeout armed once vectors are in

    tb_clk_gen i_clk_gen (.clk_o(clk));

    unified_mem_top #(.ADDR_W(ADDR_W)) i_unified_mem_top (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .fetch_addr_i (fetch_addr),
        .fetch_word_o (fetch_word),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_sel_i     (wb_sel),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat_w),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack)
    );

    always @(posedge clk) cycles <= cycles + 1;         // free running cycle count

    task automatic load_vectors();
        int                fd;
        int                n;
        string             line;
        logic [7:0]        op;
        logic [ADDR_W-1:0] addr;
        mem_pkg::sel_t     sel;
        mem_pkg::word_t    wdata;
        mem_pkg::word_t    exp_word;
        fd = $fopen("dv/mem_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file dv/mem_testdata.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin    // skip notes and blanks
                    n = $sscanf(line, "%c %h %h %h %h", op, addr, sel, wdata, exp_word);
                    if (n == 5) begin
                        vec_op.push_back(op);
                        vec_addr.push_back(addr);
                        vec_sel.push_back(sel);
                        vec_wdata.push_back(wdata);
                        vec_exp.push_back(exp_word);
                    end
                end
            end
            $fclose(fd);
        end
        if (vec_op.size() == 0) begin
            $display("no test vectors were loaded");
            errors++;
        end
    endtask

    // one classic cycle, inputs change on the falling edge
    task automatic wb_access(input logic we, input logic [ADDR_W-1:0] addr,
                             input mem_pkg::sel_t sel, input mem_pkg::word_t wdata,
                             output mem_pkg::word_t rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_sel   = sel;
        wb_adr   = addr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (wb_ack !== 1'b1) @(negedge clk);         // timeout guards this wait
        rdata  = wb_dat_r;                              // valid in the ack cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic fetch_word_at(input logic [ADDR_W-1:0] addr,
                                 output mem_pkg::word_t word);
        fetch_addr = addr;
        @(negedge clk);
        word = fetch_word;                              // one cycle after the address
    endtask

    task automatic check_ack_idle(input logic ack);
        if (ack !== 1'b0) begin
            errors++;
            $display("error at %0t: wb_ack_o high with no request pending", $time);
        end
    endtask

    task automatic check_data_word(input int idx, input logic [ADDR_W-1:0] addr,
                                   input mem_pkg::word_t got, input mem_pkg::word_t exp_word);
        tests++;
        if (got !== exp_word) begin
            errors++;
            $display("error at %0t: vector %0d data read at %h got %h expected %h",
                     $time, idx, addr, got, exp_word);
        end else begin
            $display("vector %0d data read at %h: %h ok", idx, addr, got);
        end
    endtask

    task automatic check_fetch_word(input int idx, input logic [ADDR_W-1:0] addr,
                                    input mem_pkg::word_t got, input mem_pkg::word_t exp_word);
        tests++;
        if (got !== exp_word) begin
            errors++;
            $display("error at %0t: vector %0d fetch at %h got %h expected %h",
                     $time, idx, addr, got, exp_word);
        end else begin
            $display("vector %0d fetch at %h: %h ok", idx, addr, got);
        end
    endtask

    // random idle cycles, stb low, so ack must stay low
    task automatic idle_gap();
        int unsigned gap;
        gap = $urandom % 4;
        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
            check_ack_idle(wb_ack);
        end
    endtask

    initial begin
        mem_pkg::word_t rdata;
        int unsigned    err_snap;
        void'($urandom(32'h24b5));
        rst_n      = 1'b0;
        fetch_addr = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_sel     = '0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        load_vectors();
        cycle_limit = vec_op.size() * 8 + 100;          // worst case per vector plus reset
        limit_set   = 1'b1;
        repeat (RST_CYC) @(posedge clk);                // rising edges seen in reset
        @(negedge clk);
        rst_n    = 1'b1;
        err_snap = errors;
        repeat (3) begin
            @(negedge clk);
            check_ack_idle(wb_ack);                     // nothing requested yet
        end
        tests++;
        if (errors == err_snap) begin
            $display("reset test: ack low after reset ok");
        end
        for (int i = 0; i < vec_op.size(); i++) begin
            idle_gap();
            case (vec_op[i])
                "W": begin
                    wb_access(1'b1, vec_addr[i], vec_sel[i], vec_wdata[i], rdata);
                    tests++;
                    $display("vector %0d write at %h sel %b: acked", i, vec_addr[i], vec_sel[i]);
                end
                "R": begin
                    wb_access(1'b0, vec_addr[i], vec_sel[i], vec_wdata[i], rdata);
                    check_data_word(i, vec_addr[i], rdata, vec_exp[i]);
                end
                "F": begin
                    fetch_word_at(vec_addr[i], rdata);
                    check_fetch_word(i, vec_addr[i], rdata, vec_exp[i]);
                end
                default: begin
                    errors++;
                    $display("vector %0d has an unknown operation %c", i, vec_op[i]);
                end
            endcase
        end
        @(negedge clk);
        check_ack_idle(wb_ack);
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (limit_set);
        wait (cycles >= cycle_limit);
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* dv/mem_testdata.txt */
# op addr sel wdata expect, all hex; op W = data write, R = data read, F = fetch
# expect is the little-endian word of bytes addr..addr+3, ignored for W
W 0000 f 11223344 00000000
W 0004 f 55667788 00000000
R 0000 f 00000000 11223344
R 0004 f 00000000 55667788
F 0000 0 00000000 11223344
F 0004 0 00000000 55667788
W 0000 1 000000aa 00000000
W 0004 3 0000bbcc 00000000
R 0000 f 00000000 112233aa
R 0004 f 00000000 5566bbcc
W 0000 c ddee0000 00000000
R 0000 f 00000000 ddee33aa
R 0001 f 00000000 ccddee33
R 0002 f 00000000 bbccddee
R 0003 f 00000000 66bbccdd
F 0001 0 00000000 ccddee33
F 0002 0 00000000 bbccddee
F 0003 0 00000000 66bbccdd
W 0011 f 01020304 00000000
W 0016 f a1b2c3d4 00000000
W 0023 f 0badf00d 00000000
R 0011 f 00000000 01020304
R 0016 f 00000000 a1b2c3d4
R 0023 f 00000000 0badf00d
F 0016 0 00000000 a1b2c3d4
F 0023 0 00000000 0badf00d
W fffe f cafe1234 00000000
R fffe f 00000000 cafe1234
F fffe 0 00000000 cafe1234
R 0000 f 00000000 ddeecafe
F ffff 0 00000000 eecafe12
F 0000 0 00000000 ddeecafe

/* files.f */
source/mem_pkg.sv
source/wb_data_front.sv
source/lane_steer.sv
source/byte_bank_ram.sv
source/read_realign.sv
source/unified_mem_top.sv
dv/tb_clk_gen.sv
dv/tb_unified_mem.sv

/* Bender.yml */
package:
  name: unified_mem

sources:
  - files:
      - source/mem_pkg.sv
      - source/wb_data_front.sv
      - source/lane_steer.sv
      - source/byte_bank_ram.sv
      - source/read_realign.sv
      - source/unified_mem_top.sv

  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_unified_mem.sv
